// File: design/gb_frontend_pkg.sv
// Frontend shared definitions

package gb_frontend_pkg;

	////////////////////
	// Sizes and timing

	// Words per SD block set the buffer address width
	localparam int unsigned BK_BLOCK_WORDS = 256;

	// About 0.1 s at the system clock
	localparam int unsigned FF_TAP_CYCLES = 3_200_000;

	////////////////////
	// Vector types

	typedef logic [15:0]  word_t;
	typedef logic [7:0]   file_index_t;
	typedef logic [24:0]  ioctl_addr_t;
	typedef logic [31:0]  sd_lba_t;
	typedef logic [$clog2(BK_BLOCK_WORDS)-1:0] buff_addr_t;
	typedef logic [16:0]  bk_addr_t;
	typedef logic [7:0]   ram_mask_t;
	typedef logic [127:0] palette_t;
	typedef logic [15:0]  audio_t;

	////////////////////
	// Constants

	// Host file indices
	localparam file_index_t FT_CART_DMG = 8'h01;
	localparam file_index_t FT_CART_CGB = 8'h41;
	localparam file_index_t FT_CART_ALT = 8'h80;
	localparam file_index_t FT_PALETTE  = 8'h03;
	localparam file_index_t FT_CHEAT    = 8'hFF;

	// Four 24-bit colours with the low 32 bits unused
	localparam palette_t PALETTE_RESET = 128'h828214517356305A5F1A3B4900000000;

	// Padding for the unused part of the RTC block
	localparam word_t RTC_FILL = 16'hFFFF;

	////////////////////
	// Grouped signals

	typedef struct packed {
		logic        download;
		logic        wr;
		ioctl_addr_t addr;
		word_t       dout;
		file_index_t index;
	} ioctl_t;

	typedef struct packed {
		logic cart;
		logic palette;
		logic cheat;
	} dl_class_t;

	// Integer fields arrive big endian and are kept as sent
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		sd_lba_t lba;
		logic    rd;
		logic    wr;
	} sd_cmd_t;

	typedef struct packed {
		buff_addr_t addr;
		word_t      dout;
		logic       wr;
	} sd_buff_t;

	typedef struct packed {
		bk_addr_t addr;
		word_t    data;
		logic     wr;
		logic     rtc_wr;
	} bk_port_t;

	typedef struct packed {
		logic [31:0] timestamp;
		logic [47:0] saved_time;
	} rtc_save_t;

	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} bk_state_e;

endpackage

// File: design/download_classifier.sv
// Download class decode
`timescale 1ns/1ps

module download_classifier (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  gb_frontend_pkg::ioctl_t    ioctl,
	output gb_frontend_pkg::dl_class_t dl_class,
	output logic                       cart_done
);
	logic is_cart;
	logic is_palette;
	logic is_cheat;

	// Any of the three ROM indices counts as a cart load
	assign is_cart = ioctl.download &&
		(ioctl.index == gb_frontend_pkg::FT_CART_DMG ||
		 ioctl.index == gb_frontend_pkg::FT_CART_CGB ||
		 ioctl.index == gb_frontend_pkg::FT_CART_ALT);

	assign is_palette = ioctl.download && (ioctl.index == gb_frontend_pkg::FT_PALETTE);
	assign is_cheat   = ioctl.download && (ioctl.index == gb_frontend_pkg::FT_CHEAT);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_class  <= '0;
			cart_done <= 1'b0;
		end else begin
			dl_class.cart    <= is_cart;
			dl_class.palette <= is_palette;
			dl_class.cheat   <= is_cheat;

			// Registered flag still high while the live decode has dropped
			cart_done <= dl_class.cart & ~is_cart;
		end
	end

endmodule

// File: design/palette_loader.sv
// DMG palette register
`timescale 1ns/1ps

module palette_loader (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  gb_frontend_pkg::ioctl_t    ioctl,
	input  gb_frontend_pkg::dl_class_t dl_class,
	output gb_frontend_pkg::palette_t  palette
);
	logic                   wr_q;
	gb_frontend_pkg::word_t dout_q;

	// Word stage lines up with the registered class flag
	always_ff @(posedge clk_sys) begin
		dout_q <= ioctl.dout;
		if (reset) begin
			wr_q    <= 1'b0;
			palette <= gb_frontend_pkg::PALETTE_RESET;
		end else begin
			wr_q <= ioctl.wr;
			// Bytes come in swapped within each word
			if (dl_class.palette && wr_q)
				palette <= {palette[111:0], dout_q[7:0], dout_q[15:8]};
		end
	end

endmodule

// File: design/cheat_loader.sv
// Cheat code assembly
`timescale 1ns/1ps

module cheat_loader (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  gb_frontend_pkg::ioctl_t      ioctl,
	input  gb_frontend_pkg::dl_class_t   dl_class,
	output gb_frontend_pkg::cheat_code_t cheat_code,
	output logic                         cheat_strobe,
	output logic                         cheat_clear
);
	logic                         wr_q;
	gb_frontend_pkg::ioctl_addr_t addr_q;
	gb_frontend_pkg::word_t       dout_q;
	logic                         cart_q;
	logic                         palette_q;
	logic                         code_wr;

	assign code_wr = dl_class.cheat & wr_q;

	always_ff @(posedge clk_sys) begin
		addr_q <= ioctl.addr;
		dout_q <= ioctl.dout;
		if (code_wr) begin
			case (addr_q[3:0])
				4'd0:  cheat_code.flags[15:0]    <= dout_q;
				4'd2:  cheat_code.flags[31:16]   <= dout_q;
				4'd4:  cheat_code.address[15:0]  <= dout_q;
				4'd6:  cheat_code.address[31:16] <= dout_q;
				4'd8:  cheat_code.compare[15:0]  <= dout_q;
				4'd10: cheat_code.compare[31:16] <= dout_q;
				4'd12: cheat_code.replace[15:0]  <= dout_q;
				4'd14: cheat_code.replace[31:16] <= dout_q;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_q         <= 1'b0;
			cart_q       <= 1'b0;
			palette_q    <= 1'b0;
			cheat_strobe <= 1'b0;
			cheat_clear  <= 1'b0;
		end else begin
			wr_q      <= ioctl.wr;
			cart_q    <= dl_class.cart;
			palette_q <= dl_class.palette;
			// Last word of a record hands it to the core
			cheat_strobe <= code_wr && (addr_q[3:0] == 4'd14);
			// Table is flushed at the start of a cheat file or a new cart or palette
			cheat_clear <= (code_wr && (addr_q == '0)) |
				(dl_class.cart & ~cart_q) |
				(dl_class.palette & ~palette_q);
		end
	end

endmodule

// File: design/fast_forward_control.sv
// Fast-forward latch and audio mute
`timescale 1ns/1ps

module fast_forward_control (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ff_button,
	input  logic                    osd_status,
	input  logic                    audio_mute_en,
	input  gb_frontend_pkg::ioctl_t ioctl,
	input  gb_frontend_pkg::audio_t audio_in_l,
	input  gb_frontend_pkg::audio_t audio_in_r,
	output logic                    fast_forward,
	output gb_frontend_pkg::audio_t audio_l,
	output gb_frontend_pkg::audio_t audio_r
);
	logic gated;
	logic button_q;
	logic ff_latch;
	logic ff_was_held;
	logic [$clog2(gb_frontend_pkg::FF_TAP_CYCLES + 1)-1:0] ff_count;

	// Button is ignored during downloads and while the menu is up
	assign gated = ff_button & ~ioctl.download & ~osd_status;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			button_q     <= 1'b0;
			ff_latch     <= 1'b0;
			ff_was_held  <= 1'b0;
			ff_count     <= '0;
			fast_forward <= 1'b0;
		end else begin
			button_q <= gated;
			if (gated && ff_count < gb_frontend_pkg::FF_TAP_CYCLES)
				ff_count <= ff_count + 1'b1;
			// Press
			if (gated && !button_q) begin
				ff_latch <= 1'b0;
				ff_count <= '0;
			end
			// On release a short tap latches unless the last tap already did
			if (button_q && !gated) begin
				ff_was_held <= 1'b0;
				if (ff_count < gb_frontend_pkg::FF_TAP_CYCLES && !ff_was_held) begin
					ff_was_held <= 1'b1;
					ff_latch    <= 1'b1;
				end
			end
			fast_forward <= button_q | ff_latch;
		end
	end

	assign audio_l = (fast_forward && audio_mute_en) ? '0 : audio_in_l;
	assign audio_r = (fast_forward && audio_mute_en) ? '0 : audio_in_r;

endmodule

// File: design/backup_sequencer.sv
// Save RAM transfer sequencer
`timescale 1ns/1ps

module backup_sequencer (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic                       img_nonempty,
	input  logic                       cart_has_save,
	input  logic                       cram_wr,
	input  logic                       osd_status,
	input  logic                       load_req,
	input  logic                       save_req,
	input  logic                       autosave_en,
	input  logic                       rtc_inuse,
	input  logic                       sd_ack,
	input  logic                       cart_done,
	input  gb_frontend_pkg::dl_class_t dl_class,
	input  gb_frontend_pkg::ram_mask_t ram_mask,
	output gb_frontend_pkg::sd_cmd_t   sd_cmd,
	output logic                       bk_loading,
	output logic                       sav_pending,
	output logic                       sav_supported
);
	gb_frontend_pkg::bk_state_e state;
	logic bk_ena;
	logic old_download;
	logic old_load;
	logic old_save;
	logic old_auto;
	logic old_ack;
	logic autosave;
	logic last_block;

	assign sav_supported = cart_has_save & bk_ena;
	assign autosave      = sav_pending & osd_status & autosave_en;

	// RTC games carry one extra block past the RAM image
	assign last_block = rtc_inuse ? (sd_cmd.lba[7:0] > ram_mask) :
		(sd_cmd.lba[7:0] >= ram_mask);

	////////////////////
	// Enable and pending

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena       <= 1'b0;
			old_download <= 1'b0;
			sav_pending  <= 1'b0;
		end else begin
			old_download <= dl_class.cart;
			if (dl_class.cart && !old_download)
				bk_ena <= 1'b0;
			// Host mounts the save file while the ROM is still loading
			if (dl_class.cart && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (cram_wr && !osd_status && sav_supported)
				sav_pending <= 1'b1;
			else if (state == gb_frontend_pkg::BK_XFER)
				sav_pending <= 1'b0;
		end
	end

	////////////////////
	// Block FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= gb_frontend_pkg::BK_IDLE;
			sd_cmd     <= '0;
			bk_loading <= 1'b0;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_auto   <= 1'b0;
			old_ack    <= 1'b0;
		end else begin
			old_load <= load_req;
			old_save <= save_req;
			old_auto <= autosave;
			old_ack  <= sd_ack;

			// Host took the request
			if (sd_ack && !old_ack) begin
				sd_cmd.rd <= 1'b0;
				sd_cmd.wr <= 1'b0;
			end

			case (state)
				gb_frontend_pkg::BK_IDLE: begin
					if (bk_ena && ((load_req && !old_load) || (save_req && !old_save) ||
						(autosave && !old_auto))) begin
						state      <= gb_frontend_pkg::BK_XFER;
						bk_loading <= load_req & ~old_load;
						sd_cmd.lba <= '0;
						sd_cmd.rd  <= load_req & ~old_load;
						sd_cmd.wr  <= ~(load_req & ~old_load);
					end
					// Fresh ROM pulls its save file in
					if (cart_done && img_nonempty && bk_ena) begin
						state      <= gb_frontend_pkg::BK_XFER;
						bk_loading <= 1'b1;
						sd_cmd.lba <= '0;
						sd_cmd.rd  <= 1'b1;
						sd_cmd.wr  <= 1'b0;
					end
				end
				gb_frontend_pkg::BK_XFER: begin
					if (old_ack && !sd_ack) begin
						if (last_block) begin
							state      <= gb_frontend_pkg::BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_cmd.lba <= sd_cmd.lba + 1'b1;
							sd_cmd.rd  <= bk_loading;
							sd_cmd.wr  <= ~bk_loading;
						end
					end
				end
				default: state <= gb_frontend_pkg::BK_IDLE;
			endcase
		end
	end

endmodule

// File: design/backup_block_mux.sv
// SD buffer steering for save RAM and RTC
`timescale 1ns/1ps

module backup_block_mux (
	input  gb_frontend_pkg::sd_cmd_t   sd_cmd,
	input  gb_frontend_pkg::sd_buff_t  sd_buff,
	input  logic                       sd_ack,
	input  gb_frontend_pkg::ram_mask_t ram_mask,
	input  gb_frontend_pkg::rtc_save_t rtc,
	input  gb_frontend_pkg::word_t     bk_q,
	output gb_frontend_pkg::bk_port_t  bk,
	output gb_frontend_pkg::word_t     sd_buff_din
);
	logic rtc_block;

	// Blocks past the RAM image hold the clock state
	assign rtc_block = sd_cmd.lba[7:0] > ram_mask;

	assign bk.addr   = gb_frontend_pkg::bk_addr_t'({sd_cmd.lba[7:0], sd_buff.addr});
	assign bk.data   = sd_buff.dout;
	assign bk.wr     = ~rtc_block & sd_buff.wr & sd_ack;
	assign bk.rtc_wr = rtc_block & sd_buff.wr & sd_ack;

	always_comb begin
		if (!rtc_block) begin
			sd_buff_din = bk_q;
		end else begin
			case (sd_buff.addr)
				8'd0:    sd_buff_din = rtc.timestamp[15:0];
				8'd1:    sd_buff_din = rtc.timestamp[31:16];
				8'd2:    sd_buff_din = rtc.saved_time[15:0];
				8'd3:    sd_buff_din = rtc.saved_time[31:16];
				8'd4:    sd_buff_din = rtc.saved_time[47:32];
				default: sd_buff_din = gb_frontend_pkg::RTC_FILL;
			endcase
		end
	end

endmodule

// File: design/gb_frontend.sv
// Console frontend system glue
`timescale 1ns/1ps

module gb_frontend (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  gb_frontend_pkg::ioctl_t      ioctl,
	input  logic                         ff_button,
	input  logic                         osd_status,
	input  logic                         audio_mute_en,
	input  gb_frontend_pkg::audio_t      audio_in_l,
	input  gb_frontend_pkg::audio_t      audio_in_r,
	input  logic                         img_mounted,
	input  logic                         img_readonly,
	input  logic                         img_nonempty,
	input  logic                         cart_has_save,
	input  logic                         cram_wr,
	input  logic                         load_req,
	input  logic                         save_req,
	input  logic                         autosave_en,
	input  logic                         rtc_inuse,
	input  logic                         sd_ack,
	input  gb_frontend_pkg::ram_mask_t   ram_mask,
	input  gb_frontend_pkg::rtc_save_t   rtc,
	input  gb_frontend_pkg::word_t       bk_q,
	input  gb_frontend_pkg::sd_buff_t    sd_buff,
	output gb_frontend_pkg::palette_t    palette,
	output gb_frontend_pkg::cheat_code_t cheat_code,
	output logic                         cheat_strobe,
	output logic                         cheat_clear,
	output logic                         fast_forward,
	output gb_frontend_pkg::audio_t      audio_l,
	output gb_frontend_pkg::audio_t      audio_r,
	output gb_frontend_pkg::sd_cmd_t     sd_cmd,
	output logic                         bk_loading,
	output logic                         sav_pending,
	output logic                         sav_supported,
	output gb_frontend_pkg::bk_port_t    bk,
	output gb_frontend_pkg::word_t       sd_buff_din
);
	gb_frontend_pkg::dl_class_t dl_class;
	logic                       cart_done;

	download_classifier u_classifier (.clk_sys, .reset, .ioctl, .dl_class, .cart_done);

	palette_loader u_palette (.clk_sys, .reset, .ioctl, .dl_class, .palette);

	cheat_loader u_cheat (
		.clk_sys, .reset, .ioctl, .dl_class, .cheat_code, .cheat_strobe, .cheat_clear
	);

	fast_forward_control u_ffwd (
		.clk_sys, .reset, .ff_button, .osd_status, .audio_mute_en, .ioctl,
		.audio_in_l, .audio_in_r, .fast_forward, .audio_l, .audio_r
	);

	backup_sequencer u_backup (
		.clk_sys, .reset, .img_mounted, .img_readonly, .img_nonempty, .cart_has_save,
		.cram_wr, .osd_status, .load_req, .save_req, .autosave_en, .rtc_inuse, .sd_ack,
		.cart_done, .dl_class, .ram_mask, .sd_cmd, .bk_loading, .sav_pending, .sav_supported
	);

	backup_block_mux u_block_mux (
		.sd_cmd, .sd_buff, .sd_ack, .ram_mask, .rtc, .bk_q, .bk, .sd_buff_din
	);

endmodule

// File: testbench/frontend_checker.sv
// Frontend result checker
`timescale 1ns/1ps

module frontend_checker (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      cheat_strobe,
	input  logic                      cheat_clear,
	input  gb_frontend_pkg::bk_port_t bk
);
	string test_name;
	int    test_errors;
	int    passed_tests;
	int    failed_tests;
	int    strobe_count;
	int    clear_count;
	int    ram_wr_count;
	int    rtc_wr_count;

	// Expected save RAM writes in arrival order
	gb_frontend_pkg::bk_addr_t exp_addr_q[$];
	gb_frontend_pkg::word_t    exp_data_q[$];

	task automatic check(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s %s expected %0h actual %0h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name    = name;
		test_errors  = 0;
		strobe_count = 0;
		clear_count  = 0;
		ram_wr_count = 0;
		rtc_wr_count = 0;
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("test %s: ok", test_name);
			passed_tests++;
		end else begin
			$display("test %s: %0d mismatches", test_name, test_errors);
			failed_tests++;
		end
	endtask

	task automatic expect_write(input gb_frontend_pkg::bk_addr_t addr,
		input gb_frontend_pkg::word_t data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	function automatic int writes_left();
		return exp_addr_q.size();
	endfunction

	task automatic report();
		$display("%0d tests run, %0d passed, %0d failed",
			passed_tests + failed_tests, passed_tests, failed_tests);
	endtask

	initial begin
		passed_tests = 0;
		failed_tests = 0;
		start_test("none");
	end

	////////////////////
	// Port monitor

	always @(posedge clk_sys) begin
		if (!reset) begin
			if (cheat_strobe)
				strobe_count++;
			if (cheat_clear)
				clear_count++;
			if (bk.rtc_wr)
				rtc_wr_count++;
			if (bk.wr) begin
				ram_wr_count++;
				if (exp_addr_q.size() == 0) begin
					$display("Error in %s: the save RAM was written when no write was due",
						test_name);
					test_errors++;
				end else begin
					check("bk addr", exp_addr_q.pop_front(), bk.addr);
					check("bk data", exp_data_q.pop_front(), bk.data);
				end
			end
		end
	end

endmodule

// File: testbench/tb_gb_frontend.sv
// Frontend testbench
`timescale 1ns/1ps

module tb_gb_frontend;

	localparam int WAIT_LIMIT = 2000;

	logic                         clk_sys;
	logic                         reset;
	gb_frontend_pkg::ioctl_t      ioctl;
	logic                         ff_button;
	logic                         osd_status;
	logic                         audio_mute_en;
	gb_frontend_pkg::audio_t      audio_in_l;
	gb_frontend_pkg::audio_t      audio_in_r;
	logic                         img_mounted;
	logic                         img_readonly;
	logic                         img_nonempty;
	logic                         cart_has_save;
	logic                         cram_wr;
	logic                         load_req;
	logic                         save_req;
	logic                         autosave_en;
	logic                         rtc_inuse;
	logic                         sd_ack;
	gb_frontend_pkg::ram_mask_t   ram_mask;
	gb_frontend_pkg::rtc_save_t   rtc;
	gb_frontend_pkg::word_t       bk_q;
	gb_frontend_pkg::sd_buff_t    sd_buff;
	gb_frontend_pkg::palette_t    palette;
	gb_frontend_pkg::cheat_code_t cheat_code;
	logic                         cheat_strobe;
	logic                         cheat_clear;
	logic                         fast_forward;
	gb_frontend_pkg::audio_t      audio_l;
	gb_frontend_pkg::audio_t      audio_r;
	gb_frontend_pkg::sd_cmd_t     sd_cmd;
	logic                         bk_loading;
	logic                         sav_pending;
	logic                         sav_supported;
	gb_frontend_pkg::bk_port_t    bk;
	gb_frontend_pkg::word_t       sd_buff_din;

	logic [31:0]                  rng;

	gb_frontend uut (.*);

	frontend_checker chk (.clk_sys, .reset, .cheat_strobe, .cheat_clear, .bk);

	always #50 clk_sys = ~clk_sys;

	////////////////////
	// Reference models

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Save RAM contents derived from every address bit
	function automatic gb_frontend_pkg::word_t ram_word(input gb_frontend_pkg::bk_addr_t a);
		return {a[7:0], a[15:8]} ^ {a[16], 15'h2A55};
	endfunction

	function automatic gb_frontend_pkg::palette_t palette_ref(input gb_frontend_pkg::palette_t p,
		input gb_frontend_pkg::word_t w);
		return {p[111:0], w[7:0], w[15:8]};
	endfunction

	// Word i of the download sits at seq[16*i +: 16]
	function automatic gb_frontend_pkg::cheat_code_t cheat_ref(input logic [127:0] seq);
		gb_frontend_pkg::cheat_code_t c;
		c.flags   = {seq[31:16], seq[15:0]};
		c.address = {seq[63:48], seq[47:32]};
		c.compare = {seq[95:80], seq[79:64]};
		c.replace = {seq[127:112], seq[111:96]};
		return c;
	endfunction

	function automatic gb_frontend_pkg::audio_t audio_ref(input logic ff, input logic mute,
		input gb_frontend_pkg::audio_t a);
		return (ff && mute) ? 16'h0000 : a;
	endfunction

	function automatic gb_frontend_pkg::bk_addr_t bk_addr_ref(input int blk, input int idx);
		return gb_frontend_pkg::bk_addr_t'({8'(blk), 8'(idx)});
	endfunction

	// Words the host reads back from a save block
	function automatic gb_frontend_pkg::word_t sd_word_ref(input int blk, input int idx);
		if (blk <= ram_mask)
			return ram_word(bk_addr_ref(blk, idx));
		case (idx)
			0:       return rtc.timestamp[15:0];
			1:       return rtc.timestamp[31:16];
			2:       return rtc.saved_time[15:0];
			3:       return rtc.saved_time[31:16];
			4:       return rtc.saved_time[47:32];
			default: return gb_frontend_pkg::RTC_FILL;
		endcase
	endfunction

	assign bk_q = ram_word(bk.addr);

	////////////////////
	// Host models

	task automatic wait_tick(inout int t, input string what);
		@(negedge clk_sys);
		t++;
		if (t > WAIT_LIMIT) begin
			$display("Timed out waiting for %s", what);
			$display("Some tests failed");
			$finish;
		end
	endtask

	task automatic next_word(output gb_frontend_pkg::word_t w);
		rng = xorshift(rng);
		w = rng[15:0];
	endtask

	task automatic start_download(input gb_frontend_pkg::file_index_t idx);
		@(negedge clk_sys);
		ioctl.index    = idx;
		ioctl.download = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic send_word(input int a, input gb_frontend_pkg::word_t w);
		ioctl.addr = gb_frontend_pkg::ioctl_addr_t'(a);
		ioctl.dout = w;
		ioctl.wr   = 1'b1;
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
		@(negedge clk_sys);
	endtask

	// Gives the two-cycle loader pipeline time to drain
	task automatic end_download();
		ioctl.download = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	// Host side of one SD block that fills the buffer on loads and reads it on saves
	task automatic sd_block(input logic dir_rd, input int blk);
		int                     t;
		gb_frontend_pkg::word_t w;
		t = 0;
		while (!(sd_cmd.rd || sd_cmd.wr))
			wait_tick(t, "an SD block request");
		chk.check("sd lba", blk, sd_cmd.lba);
		chk.check("sd rd", dir_rd, sd_cmd.rd);
		chk.check("sd wr", !dir_rd, sd_cmd.wr);
		sd_ack = 1'b1;
		t = 0;
		while (sd_cmd.rd || sd_cmd.wr)
			wait_tick(t, "the SD request to drop after ack");
		for (int i = 0; i < gb_frontend_pkg::BK_BLOCK_WORDS; i++) begin
			sd_buff.addr = gb_frontend_pkg::buff_addr_t'(i);
			if (dir_rd) begin
				next_word(w);
				chk.expect_write(bk_addr_ref(blk, i), w);
				sd_buff.dout = w;
				sd_buff.wr   = 1'b1;
				@(negedge clk_sys);
			end else begin
				sd_buff.wr = 1'b0;
				@(posedge clk_sys);
				chk.check("sd buffer word", sd_word_ref(blk, i), sd_buff_din);
				@(negedge clk_sys);
			end
		end
		sd_buff.wr = 1'b0;
		if (dir_rd)
			chk.check("bk_loading before ack falls", 1'b1, bk_loading);
		sd_ack = 1'b0;
		@(negedge clk_sys);
	endtask

	////////////////////
	// Test sequence

	initial begin
		int                     t;
		gb_frontend_pkg::word_t w;
		gb_frontend_pkg::palette_t exp_palette;
		logic [127:0]           seq;

		clk_sys       = 1'b0;
		reset         = 1'b1;
		ioctl         = '0;
		ff_button     = 1'b0;
		osd_status    = 1'b0;
		audio_mute_en = 1'b1;
		audio_in_l    = 16'h1234;
		audio_in_r    = 16'hBEEF;
		img_mounted   = 1'b0;
		img_readonly  = 1'b0;
		img_nonempty  = 1'b0;
		cart_has_save = 1'b1;
		cram_wr       = 1'b0;
		load_req      = 1'b0;
		save_req      = 1'b0;
		autosave_en   = 1'b0;
		rtc_inuse     = 1'b0;
		sd_ack        = 1'b0;
		ram_mask      = 8'd1;
		rtc           = {32'h6502_1A7C, 48'h0012_3456_789A};
		sd_buff       = '0;
		rng           = 32'h9300;

		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		chk.start_test("palette_reset");
		chk.check("palette", gb_frontend_pkg::PALETTE_RESET, palette);
		chk.end_test();

		chk.start_test("palette_load");
		exp_palette = gb_frontend_pkg::PALETTE_RESET;
		start_download(gb_frontend_pkg::FT_PALETTE);
		for (int i = 0; i < 8; i++) begin
			next_word(w);
			exp_palette = palette_ref(exp_palette, w);
			send_word(2 * i, w);
		end
		end_download();
		chk.check("palette", exp_palette, palette);
		chk.end_test();

		chk.start_test("cheat_record");
		seq = '0;
		start_download(gb_frontend_pkg::FT_CHEAT);
		for (int i = 0; i < 8; i++) begin
			next_word(w);
			seq[16*i +: 16] = w;
			send_word(2 * i, w);
		end
		end_download();
		chk.check("cheat_code", cheat_ref(seq), cheat_code);
		chk.check("strobe count", 1, chk.strobe_count);
		chk.check("clear count", 1, chk.clear_count);
		chk.end_test();

		chk.start_test("cheat_cart_clear");
		start_download(gb_frontend_pkg::FT_CART_DMG);
		end_download();
		chk.check("clear count", 1, chk.clear_count);
		chk.end_test();

		chk.start_test("ff_hold");
		ff_button = 1'b1;
		t = 0;
		while (!fast_forward)
			wait_tick(t, "fast_forward to rise");
		repeat (8) @(negedge clk_sys);
		chk.check("fast_forward", 1'b1, fast_forward);
		chk.check("audio_l", audio_ref(1'b1, audio_mute_en, audio_in_l), audio_l);
		chk.check("audio_r", audio_ref(1'b1, audio_mute_en, audio_in_r), audio_r);
		chk.end_test();

		// The hold above was shorter than the tap window
		chk.start_test("ff_tap_latch");
		ff_button = 1'b0;
		repeat (6) @(negedge clk_sys);
		chk.check("fast_forward", 1'b1, fast_forward);
		chk.end_test();

		chk.start_test("ff_tap_unlatch");
		ff_button = 1'b1;
		repeat (3) @(negedge clk_sys);
		ff_button = 1'b0;
		t = 0;
		while (fast_forward)
			wait_tick(t, "fast_forward to fall");
		repeat (6) @(negedge clk_sys);
		chk.check("fast_forward", 1'b0, fast_forward);
		chk.check("audio_l", audio_ref(1'b0, audio_mute_en, audio_in_l), audio_l);
		chk.end_test();

		chk.start_test("ff_osd_open");
		osd_status = 1'b1;
		ff_button  = 1'b1;
		repeat (8) @(negedge clk_sys);
		chk.check("fast_forward", 1'b0, fast_forward);
		ff_button  = 1'b0;
		osd_status = 1'b0;
		repeat (4) @(negedge clk_sys);
		chk.end_test();

		// Writable image mounted during an empty-image cart load enables saving
		chk.start_test("save_rtc");
		ram_mask    = 8'd1;
		rtc_inuse   = 1'b1;
		img_mounted = 1'b1;
		start_download(gb_frontend_pkg::FT_CART_CGB);
		end_download();
		chk.check("sav_supported", 1'b1, sav_supported);
		cram_wr = 1'b1;
		@(negedge clk_sys);
		cram_wr = 1'b0;
		t = 0;
		while (!sav_pending)
			wait_tick(t, "sav_pending to rise");
		save_req = 1'b1;
		for (int b = 0; b < 3; b++)
			sd_block(1'b0, b);
		save_req = 1'b0;
		repeat (6) @(negedge clk_sys);
		chk.check("sd request after save", 2'b00, {sd_cmd.rd, sd_cmd.wr});
		chk.check("sav_pending", 1'b0, sav_pending);
		chk.end_test();

		chk.start_test("load_cart");
		ram_mask     = 8'd2;
		rtc_inuse    = 1'b0;
		img_nonempty = 1'b1;
		start_download(gb_frontend_pkg::FT_CART_DMG);
		end_download();
		for (int b = 0; b < 3; b++)
			sd_block(1'b1, b);
		t = 0;
		while (bk_loading)
			wait_tick(t, "bk_loading to fall");
		repeat (6) @(negedge clk_sys);
		chk.check("sd request after load", 2'b00, {sd_cmd.rd, sd_cmd.wr});
		chk.check("ram write count", 3 * gb_frontend_pkg::BK_BLOCK_WORDS, chk.ram_wr_count);
		chk.check("missing ram writes", 0, chk.writes_left());
		chk.check("rtc write count", 0, chk.rtc_wr_count);
		chk.end_test();

		chk.report();
		if (chk.failed_tests == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: filelist.f
design/gb_frontend_pkg.sv
design/download_classifier.sv
design/palette_loader.sv
design/cheat_loader.sv
design/fast_forward_control.sv
design/backup_sequencer.sv
design/backup_block_mux.sv
design/gb_frontend.sv
testbench/frontend_checker.sv
testbench/tb_gb_frontend.sv

// File: Bender.yml
package:
  name: gb_frontend

sources:
  - design/gb_frontend_pkg.sv
  - design/download_classifier.sv
  - design/palette_loader.sv
  - design/cheat_loader.sv
  - design/fast_forward_control.sv
  - design/backup_sequencer.sv
  - design/backup_block_mux.sv
  - design/gb_frontend.sv
  - target: test
    files:
      - testbench/frontend_checker.sv
      - testbench/tb_gb_frontend.sv
